// ==== mem_ex_pkg.sv ====
package mem_ex_pkg;

    // producer tag, 0 is reserved for "no producer"
    localparam int TAG_W = 4;

    // operand value
    localparam int VAL_W = 32;

    // fixed part field widths
    localparam int EIP_W    = 32;
    localparam int ALUK_W   = 5;
    localparam int OPSIZE_W = 2;

    // one source operand, 37 bits
    typedef struct packed {
        logic [VAL_W-1:0] value;
        logic [TAG_W-1:0] tag;
        logic             ready;
    } opnd_t;

    // modifiable part, rewritten by result broadcasts while queued
    typedef struct packed {
        opnd_t op1;
        opnd_t op2;
    } m_payload_t;

    // fixed part, written once on push
    typedef struct packed {
        logic [EIP_W-1:0]    eip;
        logic [ALUK_W-1:0]   aluk;
        logic [OPSIZE_W-1:0] opsize;
        logic [TAG_W-1:0]    dest_tag;
    } n_payload_t;

    // total widths, handy for dumps and checks
    localparam int OPND_W = $bits(opnd_t);
    localparam int M_W    = $bits(m_payload_t);
    localparam int N_W    = $bits(n_payload_t);

endpackage

// ==== queue_pkg.sv ====
package queue_pkg;

    // slot count used when the top level is not overridden
    localparam int DEFAULT_Q_LENGTH = 8;

    // what the queue does in a given cycle
    typedef enum logic [2:0] {
        Q_IDLE     = 3'd0,
        Q_PUSH     = 3'd1,
        Q_POP      = 3'd2,
        Q_PUSH_POP = 3'd3,
        // flush, wins over push and pop
        Q_CLEAR    = 3'd4
    } q_op_t;

endpackage

// ==== queue_ctrl.sv ====
module queue_ctrl #(
    parameter int Q_LENGTH = queue_pkg::DEFAULT_Q_LENGTH,
    localparam int IDX_W = $clog2(Q_LENGTH)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wr,
    input  logic                rd,
    input  logic                clr,
    output logic                full,
    output logic                empty,
    output logic [Q_LENGTH-1:0] wr_slot,
    output logic [IDX_W-1:0]    rd_ptr,
    output logic [Q_LENGTH-1:0] slot_valid
);

    localparam int CNT_W = $clog2(Q_LENGTH + 1);

    queue_pkg::q_op_t    op;
    logic                push_ok;
    logic                pop_ok;
    logic                do_push;
    logic                do_pop;
    logic [IDX_W-1:0]    wr_ptr;
    logic [CNT_W-1:0]    count;
    logic [Q_LENGTH-1:0] pop_mask;

    // pointers wrap at Q_LENGTH, which need not be a power of two
    function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
        if (p == IDX_W'(Q_LENGTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // a full queue still takes a push when the head leaves in the same cycle
    assign push_ok = wr && (!full || rd);
    assign pop_ok  = rd && !empty;

    always_comb begin
        if (clr) begin
            op = queue_pkg::Q_CLEAR;
        end else if (push_ok && pop_ok) begin
            op = queue_pkg::Q_PUSH_POP;
        end else if (push_ok) begin
            op = queue_pkg::Q_PUSH;
        end else if (pop_ok) begin
            op = queue_pkg::Q_POP;
        end else begin
            op = queue_pkg::Q_IDLE;
        end
    end

    assign do_push = (op == queue_pkg::Q_PUSH) || (op == queue_pkg::Q_PUSH_POP);
    assign do_pop  = (op == queue_pkg::Q_POP) || (op == queue_pkg::Q_PUSH_POP);

    assign wr_slot  = do_push ? (Q_LENGTH'(1) << wr_ptr) : '0;
    assign pop_mask = do_pop ? (Q_LENGTH'(1) << rd_ptr) : '0;

    assign full  = (count == CNT_W'(Q_LENGTH));
    assign empty = (count == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot_valid <= '0;
        end else if (op == queue_pkg::Q_CLEAR) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot_valid <= '0;
        end else begin
            // on push-pop when full the head slot is vacated and refilled
            slot_valid <= (slot_valid & ~pop_mask) | wr_slot;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    a_full_empty_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(full && empty));

    a_wr_slot_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(wr_slot));

    // occupancy count and valid bits must stay in step
    a_count_matches: assert property (@(posedge clk) disable iff (!arst_n)
        $countones(slot_valid) == int'(count));

endmodule

// ==== slot_array.sv ====
module slot_array #(
    parameter type payload_t = logic [7:0],
    parameter int Q_LENGTH = queue_pkg::DEFAULT_Q_LENGTH,
    localparam int IDX_W = $clog2(Q_LENGTH)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [Q_LENGTH-1:0] load,
    input  payload_t            load_data [Q_LENGTH],
    input  logic [IDX_W-1:0]    rd_ptr,
    output payload_t            entries [Q_LENGTH],
    output payload_t            dout
);

    // slot storage
    payload_t mem [Q_LENGTH];

    // each slot loads on its own strobe, content is meaningless until valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (load[i]) begin
                mem[i] <= load_data[i];
            end
        end
    end

    // every slot is visible for the wakeup logic
    always_comb begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            entries[i] = mem[i];
        end
    end

    // head read mux
    assign dout = mem[rd_ptr];

    // non power of two lengths leave unused pointer codes
    a_rd_ptr_range: assert property (@(posedge clk) disable iff (!arst_n)
        int'(rd_ptr) < Q_LENGTH);

endmodule

// ==== operand_wakeup.sv ====
module operand_wakeup #(
    parameter int Q_LENGTH = queue_pkg::DEFAULT_Q_LENGTH
) (
    input  logic                           wb_valid,
    input  logic [mem_ex_pkg::TAG_W-1:0]   wb_tag,
    input  logic [mem_ex_pkg::VAL_W-1:0]   wb_val,
    input  mem_ex_pkg::m_payload_t         m_din,
    input  logic [Q_LENGTH-1:0]            wr_slot,
    input  logic [Q_LENGTH-1:0]            slot_valid,
    input  mem_ex_pkg::m_payload_t         m_entries [Q_LENGTH],
    output logic [Q_LENGTH-1:0]            m_load,
    output mem_ex_pkg::m_payload_t         m_load_data [Q_LENGTH]
);

    // tag 0 never matches, it marks an operand with no producer
    logic bc_live;

    function automatic mem_ex_pkg::opnd_t wake(
        input mem_ex_pkg::opnd_t             o,
        input logic                          hit,
        input logic [mem_ex_pkg::VAL_W-1:0]  v
    );
        mem_ex_pkg::opnd_t r;
        r = o;
        if (hit) begin
            r.value = v;
            r.ready = 1'b1;
        end
        return r;
    endfunction

    assign bc_live = wb_valid && (wb_tag != '0);

    for (genvar i = 0; i < Q_LENGTH; i++) begin : g_slot
        mem_ex_pkg::m_payload_t src;
        logic                   hit1;
        logic                   hit2;

        // incoming micro-op takes the broadcast too
        assign src = wr_slot[i] ? m_din : m_entries[i];

        assign hit1 = bc_live && !src.op1.ready && (src.op1.tag == wb_tag);
        assign hit2 = bc_live && !src.op2.ready && (src.op2.tag == wb_tag);

        assign m_load_data[i] = '{op1: wake(src.op1, hit1, wb_val),
                                  op2: wake(src.op2, hit2, wb_val)};

        // empty slots are never touched by a broadcast
        assign m_load[i] = wr_slot[i] || (slot_valid[i] && (hit1 || hit2));
    end

    // a stored ready operand must reach the array unchanged
    always_comb begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (m_load[i] && !wr_slot[i]) begin
                a_keep_ready1: assert (!m_entries[i].op1.ready ||
                                       m_load_data[i].op1 == m_entries[i].op1)
                    else $error("ready op1 of slot %0d rewritten by broadcast", i);
                a_keep_ready2: assert (!m_entries[i].op2.ready ||
                                       m_load_data[i].op2 == m_entries[i].op2)
                    else $error("ready op2 of slot %0d rewritten by broadcast", i);
            end
        end
    end

endmodule

// ==== mem_ex_queue.sv ====
module mem_ex_queue #(
    parameter int Q_LENGTH = queue_pkg::DEFAULT_Q_LENGTH
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wr,
    input  logic                          rd,
    input  logic                          clr,
    input  mem_ex_pkg::m_payload_t        m_din,
    input  mem_ex_pkg::n_payload_t        n_din,
    input  logic                          wb_valid,
    input  logic [mem_ex_pkg::TAG_W-1:0]  wb_tag,
    input  logic [mem_ex_pkg::VAL_W-1:0]  wb_val,
    output logic                          full,
    output logic                          empty,
    output mem_ex_pkg::m_payload_t        m_dout,
    output mem_ex_pkg::n_payload_t        n_dout
);

    localparam int IDX_W = $clog2(Q_LENGTH);

    logic [Q_LENGTH-1:0]     wr_slot;
    logic [Q_LENGTH-1:0]     slot_valid;
    logic [IDX_W-1:0]        rd_ptr;
    logic [Q_LENGTH-1:0]     m_load;
    mem_ex_pkg::m_payload_t  m_load_data [Q_LENGTH];
    mem_ex_pkg::m_payload_t  m_entries [Q_LENGTH];
    mem_ex_pkg::n_payload_t  n_load_data [Q_LENGTH];

    // fixed part goes to whichever slot is selected for the push
    for (genvar i = 0; i < Q_LENGTH; i++) begin : g_n_fan
        assign n_load_data[i] = n_din;
    end

    queue_ctrl #(
        .Q_LENGTH (Q_LENGTH)
    ) i_queue_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr         (wr),
        .rd         (rd),
        .clr        (clr),
        .full       (full),
        .empty      (empty),
        .wr_slot    (wr_slot),
        .rd_ptr     (rd_ptr),
        .slot_valid (slot_valid)
    );

    operand_wakeup #(
        .Q_LENGTH (Q_LENGTH)
    ) i_operand_wakeup (
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_val      (wb_val),
        .m_din       (m_din),
        .wr_slot     (wr_slot),
        .slot_valid  (slot_valid),
        .m_entries   (m_entries),
        .m_load      (m_load),
        .m_load_data (m_load_data)
    );

    // modifiable part, reloaded on push and on wakeup
    slot_array #(
        .payload_t (mem_ex_pkg::m_payload_t),
        .Q_LENGTH  (Q_LENGTH)
    ) i_m_slots (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (m_load),
        .load_data (m_load_data),
        .rd_ptr    (rd_ptr),
        .entries   (m_entries),
        .dout      (m_dout)
    );

    // fixed part, loaded on push only
    slot_array #(
        .payload_t (mem_ex_pkg::n_payload_t),
        .Q_LENGTH  (Q_LENGTH)
    ) i_n_slots (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (wr_slot),
        .load_data (n_load_data),
        .rd_ptr    (rd_ptr),
        .entries   (),
        .dout      (n_dout)
    );

endmodule

// ==== tb_mem_ex_queue.sv ====
module tb_mem_ex_queue;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Q_LEN = 4;
    localparam int TW = mem_ex_pkg::TAG_W;
    localparam int VW = mem_ex_pkg::VAL_W;
    localparam int WAIT_LIMIT = 4 * Q_LEN + 8;

    logic                   clk;
    logic                   arst_n;
    logic                   wr;
    logic                   rd;
    logic                   clr;
    mem_ex_pkg::m_payload_t m_din;
    mem_ex_pkg::n_payload_t n_din;
    logic                   wb_valid;
    logic [TW-1:0]          wb_tag;
    logic [VW-1:0]          wb_val;
    logic                   full;
    logic                   empty;
    mem_ex_pkg::m_payload_t m_dout;
    mem_ex_pkg::n_payload_t n_dout;

    // model queue with the head at index 0
    mem_ex_pkg::m_payload_t m_model [$];
    mem_ex_pkg::n_payload_t n_model [$];

    int    seed = 32'h936a_8571;
    int    errors = 0;
    int    checks = 0;
    int    timeouts = 0;
    int    tests_run = 0;
    int    tests_ok = 0;
    int    test_mark = 0;
    string test_name;

    mem_ex_queue #(
        .Q_LENGTH (Q_LEN)
    ) i_mem_ex_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (wr),
        .rd       (rd),
        .clr      (clr),
        .m_din    (m_din),
        .n_din    (n_din),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_val   (wb_val),
        .full     (full),
        .empty    (empty),
        .m_dout   (m_dout),
        .n_dout   (n_dout)
    );

    always #10 clk = ~clk;

    function automatic mem_ex_pkg::opnd_t make_opnd(input logic [VW-1:0] v,
                                                    input logic [TW-1:0] t,
                                                    input logic r);
        mem_ex_pkg::opnd_t o;
        o.value = v;
        o.tag   = t;
        o.ready = r;
        return o;
    endfunction

    // a waiting operand with a matching nonzero tag takes a live broadcast
    function automatic mem_ex_pkg::opnd_t ref_wake(input mem_ex_pkg::opnd_t o,
                                                   input logic bv,
                                                   input logic [TW-1:0] bt,
                                                   input logic [VW-1:0] bval);
        mem_ex_pkg::opnd_t r;
        r = o;
        if (bv && !o.ready && (o.tag == bt) && (bt != '0)) begin
            r.value = bval;
            r.ready = 1'b1;
        end
        return r;
    endfunction

    function automatic mem_ex_pkg::m_payload_t ref_wake_entry(
        input mem_ex_pkg::m_payload_t e,
        input logic bv,
        input logic [TW-1:0] bt,
        input logic [VW-1:0] bval
    );
        mem_ex_pkg::m_payload_t r;
        r.op1 = ref_wake(e.op1, bv, bt, bval);
        r.op2 = ref_wake(e.op2, bv, bt, bval);
        return r;
    endfunction

    function automatic queue_pkg::q_op_t ref_decode(input logic w, input logic r,
                                                    input logic c, input int occ);
        logic push_ok;
        logic pop_ok;
        push_ok = w && ((occ < Q_LEN) || r);
        pop_ok  = r && (occ > 0);
        if (c) begin
            return queue_pkg::Q_CLEAR;
        end
        if (push_ok && pop_ok) begin
            return queue_pkg::Q_PUSH_POP;
        end
        if (push_ok) begin
            return queue_pkg::Q_PUSH;
        end
        if (pop_ok) begin
            return queue_pkg::Q_POP;
        end
        return queue_pkg::Q_IDLE;
    endfunction

    // one clock edge of the queue rules applied to the model
    function automatic void ref_cycle(input logic w, input logic r, input logic c,
                                      input mem_ex_pkg::m_payload_t md,
                                      input mem_ex_pkg::n_payload_t nd,
                                      input logic bv,
                                      input logic [TW-1:0] bt,
                                      input logic [VW-1:0] bval);
        queue_pkg::q_op_t op;
        op = ref_decode(w, r, c, m_model.size());
        if (op == queue_pkg::Q_CLEAR) begin
            m_model.delete();
            n_model.delete();
            return;
        end
        for (int i = 0; i < m_model.size(); i++) begin
            m_model[i] = ref_wake_entry(m_model[i], bv, bt, bval);
        end
        if ((op == queue_pkg::Q_POP) || (op == queue_pkg::Q_PUSH_POP)) begin
            void'(m_model.pop_front());
            void'(n_model.pop_front());
        end
        if ((op == queue_pkg::Q_PUSH) || (op == queue_pkg::Q_PUSH_POP)) begin
            m_model.push_back(ref_wake_entry(md, bv, bt, bval));
            n_model.push_back(nd);
        end
    endfunction

    task automatic check_m(input string name, input mem_ex_pkg::m_payload_t exp,
                           input mem_ex_pkg::m_payload_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_n(input string name, input mem_ex_pkg::n_payload_t exp,
                           input mem_ex_pkg::n_payload_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flags(input logic exp_full, input logic exp_empty,
                               input logic act_full, input logic act_empty);
        checks++;
        if (act_full !== exp_full) begin
            errors++;
            $display("[FAIL] %0t full expected %b got %b", $time, exp_full, act_full);
        end
        if (act_empty !== exp_empty) begin
            errors++;
            $display("[FAIL] %0t empty expected %b got %b", $time, exp_empty, act_empty);
        end
    endtask

    // outputs still hold the state left by the previous edge here
    always @(posedge clk) begin
        if (!arst_n) begin
            m_model.delete();
            n_model.delete();
        end else begin
            check_flags(m_model.size() == Q_LEN, m_model.size() == 0, full, empty);
            if (m_model.size() != 0) begin
                check_m("m_dout", m_model[0], m_dout);
                check_n("n_dout", n_model[0], n_dout);
            end
            ref_cycle(wr, rd, clr, m_din, n_din, wb_valid, wb_tag, wb_val);
        end
    end

    function automatic mem_ex_pkg::m_payload_t rand_m(input logic [TW-1:0] tag_mask);
        logic [95:0]            raw;
        mem_ex_pkg::m_payload_t p;
        raw = {$random(seed), $random(seed), $random(seed)};
        p = raw[mem_ex_pkg::M_W-1:0];
        p.op1.tag = p.op1.tag & tag_mask;
        p.op2.tag = p.op2.tag & tag_mask;
        return p;
    endfunction

    function automatic mem_ex_pkg::n_payload_t rand_n();
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        return raw[mem_ex_pkg::N_W-1:0];
    endfunction

    task automatic set_inputs(input logic w, input logic r, input logic c,
                              input mem_ex_pkg::m_payload_t md,
                              input mem_ex_pkg::n_payload_t nd);
        wr       = w;
        rd       = r;
        clr      = c;
        m_din    = md;
        n_din    = nd;
        wb_valid = 1'b0;
        wb_tag   = '0;
        wb_val   = '0;
    endtask

    task automatic drive_cycle(input logic w, input logic r, input logic c,
                               input mem_ex_pkg::m_payload_t md,
                               input mem_ex_pkg::n_payload_t nd);
        @(negedge clk);
        set_inputs(w, r, c, md, nd);
    endtask

    // same falling edge as the preceding drive_cycle
    task automatic bcast(input logic v, input logic [TW-1:0] t, input logic [VW-1:0] val);
        wb_valid = v;
        wb_tag   = t;
        wb_val   = val;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic fill_queue();
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (full) begin
                done = 1'b1;
            end else if (n >= WAIT_LIMIT) begin
                note_timeout("queue never reported full while pushing");
                done = 1'b1;
            end else begin
                set_inputs(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
                n++;
            end
        end
        set_inputs(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic drain_queue();
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (empty) begin
                done = 1'b1;
            end else if (n >= WAIT_LIMIT) begin
                note_timeout("queue never reported empty while popping");
                done = 1'b1;
            end else begin
                set_inputs(1'b0, 1'b1, 1'b0, '0, '0);
                n++;
            end
        end
        set_inputs(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_mark = errors + timeouts;
    endtask

    task automatic end_test();
        idle_cycle();
        idle_cycle();
        tests_run++;
        if (errors + timeouts == test_mark) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("test %0d %s: %0d problem(s)", tests_run, test_name,
                     errors + timeouts - test_mark);
        end
    endtask

    task automatic test_order();
        begin_test("push order");
        for (int i = 0; i < Q_LEN - 1; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        end
        drain_queue();
        end_test();
    endtask

    task automatic test_drops();
        begin_test("dropped push and pop");
        fill_queue();
        drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        @(negedge clk);
        check_flags(1'b1, 1'b0, full, empty);
        set_inputs(1'b0, 1'b0, 1'b0, '0, '0);
        drain_queue();
        drive_cycle(1'b0, 1'b1, 1'b0, '0, '0);
        drive_cycle(1'b0, 1'b1, 1'b0, '0, '0);
        @(negedge clk);
        check_flags(1'b0, 1'b1, full, empty);
        set_inputs(1'b0, 1'b0, 1'b0, '0, '0);
        end_test();
    endtask

    task automatic test_full_push_pop();
        begin_test("push with pop while full");
        fill_queue();
        for (int i = 0; i < Q_LEN + 2; i++) begin
            drive_cycle(1'b1, 1'b1, 1'b0, rand_m('1), rand_n());
        end
        drain_queue();
        end_test();
    endtask

    task automatic test_clear();
        begin_test("clear");
        drive_cycle(1'b0, 1'b0, 1'b1, '0, '0);
        drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        // clear beats a push in the same cycle
        drive_cycle(1'b1, 1'b1, 1'b1, rand_m('1), rand_n());
        fill_queue();
        drive_cycle(1'b0, 1'b0, 1'b1, '0, '0);
        for (int i = 0; i < Q_LEN - 1; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b0, rand_m('1), rand_n());
        end
        drain_queue();
        end_test();
    endtask

    task automatic test_wakeup_queued();
        mem_ex_pkg::m_payload_t e [4];
        begin_test("wakeup of queued entries");
        e[0] = '{op1: make_opnd(32'h11, 4'd5, 1'b0), op2: make_opnd(32'h22, 4'd5, 1'b1)};
        e[1] = '{op1: make_opnd(32'h33, 4'd3, 1'b0), op2: make_opnd(32'h44, 4'd0, 1'b0)};
        e[2] = '{op1: make_opnd(32'h55, 4'd5, 1'b0), op2: make_opnd(32'h66, 4'd0, 1'b1)};
        e[3] = '{op1: make_opnd(32'h77, 4'd5, 1'b0), op2: make_opnd(32'h88, 4'd5, 1'b0)};
        for (int i = 0; i < Q_LEN; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b0, e[i], rand_n());
        end
        idle_cycle();
        bcast(1'b1, 4'd5, 32'hcafe_0005);
        // tag 0 must never match
        idle_cycle();
        bcast(1'b1, 4'd0, 32'hdead_0000);
        idle_cycle();
        bcast(1'b0, 4'd3, 32'hbad0_0003);
        drive_cycle(1'b0, 1'b1, 1'b0, '0, '0);
        bcast(1'b1, 4'd3, 32'hbeef_0003);
        drain_queue();
        end_test();
    endtask

    task automatic test_wakeup_on_push();
        mem_ex_pkg::m_payload_t a;
        mem_ex_pkg::m_payload_t b;
        mem_ex_pkg::m_payload_t a_exp;
        begin_test("wakeup on push");
        a = '{op1: make_opnd(32'h101, 4'd7, 1'b0), op2: make_opnd(32'h102, 4'd2, 1'b0)};
        b = '{op1: make_opnd(32'h201, 4'd9, 1'b1), op2: make_opnd(32'h202, 4'd9, 1'b0)};
        a_exp = '{op1: make_opnd(32'h7777_0007, 4'd7, 1'b1), op2: a.op2};
        drive_cycle(1'b1, 1'b0, 1'b0, a, rand_n());
        bcast(1'b1, 4'd7, 32'h7777_0007);
        drive_cycle(1'b1, 1'b0, 1'b0, b, rand_n());
        bcast(1'b1, 4'd9, 32'h9999_0009);
        check_m("m_dout", a_exp, m_dout);
        drain_queue();
        end_test();
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        begin_test("random mix");
        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            // small tags so broadcasts often hit
            drive_cycle(r[0], r[1], r[7:4] == 4'hf, rand_m(TW'(3)), rand_n());
            if (r[2]) begin
                bcast(1'b1, TW'(r[9:8]), $random(seed));
            end
        end
        drain_queue();
        end_test();
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        set_inputs(1'b0, 1'b0, 1'b0, '0, '0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_order();
        test_drops();
        test_full_push_pop();
        test_clear();
        test_wakeup_queued();
        test_wakeup_on_push();
        test_random_mix();

        $display("tests %0d, passed %0d, checks %0d, errors %0d, timeouts %0d",
                 tests_run, tests_ok, checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
mem_ex_pkg.sv
queue_pkg.sv
queue_ctrl.sv
slot_array.sv
operand_wakeup.sv
mem_ex_queue.sv
tb_mem_ex_queue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem/ex queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_ex_queue -f filelist.f -o sim_tb

status=0
out=$(./obj_dir/sim_tb) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
